// ==== src/gcode_cfg.svh ====
`ifndef GCODE_CFG_SVH
`define GCODE_CFG_SVH

// ascii character width.
`define CHAR_BITS 8

// signed width of the integer result.
`define POS_BITS 14

// signed width of the result in hundredths.
`define PRECISE_BITS 21

// largest integer magnitude that is accepted.
`define POS_MAX 8191

// character FIFO size, the depth must be a power of two.
`define FIFO_DEPTH 128
`define FIFO_ADDR_BITS 7

`endif

// ==== src/gcode_pkg.sv ====
`include "gcode_cfg.svh"

package gcode_pkg;

	typedef logic [`CHAR_BITS-1:0] char_t;
	typedef logic [3:0] digit_t;
	typedef logic signed [`POS_BITS-1:0] pos_t;
	typedef logic signed [`PRECISE_BITS-1:0] precise_t;
	typedef logic [`POS_BITS-1:0] mag_t;
	typedef logic [6:0] hund_t; // holds 0 to 99.

	typedef enum logic [3:0] {
		IDLE,
		FETCH,
		WAIT_CHAR,
		LEAD_SPACE,
		POST_TITLE,
		SIGN_OR_DIGIT,
		INT_DIGITS,
		FRAC_DIGITS,
		FINISH
	} scan_state_e;

	typedef struct packed {
		logic clear;
		logic int_digit;
		logic frac_digit;
		digit_t value;
	} digit_ev_t;

	typedef struct packed {
		logic finish;
		logic negative;
		logic saw_digit;
		logic syntax_error;
	} scan_status_t;

	typedef struct packed {
		mag_t mag;
		logic overflow;
	} accum_int_t;

endpackage

// ==== src/char_fifo.sv ====
`timescale 1ns/1ps
`include "gcode_cfg.svh"

module char_fifo (
	input logic sub_intf,
	input logic arst_n,
	input logic wr_en,
	input gcode_pkg::char_t wr_data,
	input logic rd_en,
	output gcode_pkg::char_t rd_data,
	output logic empty,
	output logic full
);

	localparam logic [`FIFO_ADDR_BITS:0] DEPTH = `FIFO_DEPTH;

	gcode_pkg::char_t mem [`FIFO_DEPTH];
	logic [`FIFO_ADDR_BITS-1:0] wr_ptr;
	logic [`FIFO_ADDR_BITS-1:0] rd_ptr;
	logic [`FIFO_ADDR_BITS:0] count;
	logic wr_ok;
	logic rd_ok;

	assign wr_ok = wr_en && !full; // writes into a full buffer are dropped.
	assign rd_ok = rd_en && !empty;
	assign empty = count == '0;
	assign full = count == DEPTH;

	always_ff @(posedge sub_intf) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_data;
		end
		if (rd_ok) begin
			rd_data <= mem[rd_ptr]; // valid on the cycle after rd_en.
		end
	end

	always_ff @(posedge sub_intf or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at the depth.
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr_ok && !rd_ok) begin
				count <= count + 1'b1;
			end else if (rd_ok && !wr_ok) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== src/arg_scanner.sv ====
`timescale 1ns/1ps

module arg_scanner (
	input logic sub_intf,
	input logic arst_n,
	input logic start,
	input gcode_pkg::char_t title,
	input gcode_pkg::char_t rd_data,
	input logic empty,
	output logic rd_en,
	output gcode_pkg::digit_ev_t ev,
	output gcode_pkg::scan_status_t status,
	output logic rdy
);

	localparam gcode_pkg::char_t CHAR_SPACE = 8'h20;
	localparam gcode_pkg::char_t CHAR_NL = 8'h0a;
	localparam gcode_pkg::char_t CHAR_MINUS = 8'h2d;
	localparam gcode_pkg::char_t CHAR_DOT = 8'h2e;
	localparam gcode_pkg::char_t CHAR_ZERO = 8'h30;
	localparam gcode_pkg::char_t CHAR_NINE = 8'h39;

	gcode_pkg::scan_state_e state;
	gcode_pkg::scan_state_e state_next;
	gcode_pkg::scan_state_e phase; // where in the argument the next character lands.
	gcode_pkg::scan_state_e phase_next;
	gcode_pkg::char_t title_q;
	logic negative_q;
	logic saw_digit_q;
	logic syntax_error_q;
	logic neg_next;
	logic saw_next;
	logic err_next;
	logic finish_d;
	logic is_digit;
	logic is_end;

	assign is_digit = (rd_data >= CHAR_ZERO) && (rd_data <= CHAR_NINE);
	assign is_end = (rd_data == CHAR_SPACE) || (rd_data == CHAR_NL);
	assign rdy = (state == gcode_pkg::IDLE) && !finish_d; // stays low through the done cycle.

	assign status.finish = state == gcode_pkg::FINISH;
	assign status.negative = negative_q;
	assign status.saw_digit = saw_digit_q;
	assign status.syntax_error = syntax_error_q;

	always_comb begin
		state_next = state;
		phase_next = phase;
		neg_next = negative_q;
		saw_next = saw_digit_q;
		err_next = syntax_error_q;
		rd_en = 1'b0;
		ev = '0;
		ev.value = rd_data[3:0]; // the low nibble of an ascii digit is its value.
		case (state)
			gcode_pkg::IDLE: begin
				if (start && rdy) begin
					ev.clear = 1'b1;
					state_next = gcode_pkg::FETCH;
					phase_next = gcode_pkg::LEAD_SPACE;
					neg_next = 1'b0;
					saw_next = 1'b0;
					err_next = 1'b0;
				end
			end
			gcode_pkg::FETCH: begin
				if (!empty) begin
					rd_en = 1'b1;
					state_next = gcode_pkg::WAIT_CHAR;
				end
			end
			gcode_pkg::WAIT_CHAR: begin
				state_next = gcode_pkg::FETCH;
				case (phase)
					gcode_pkg::LEAD_SPACE: begin
						if (rd_data == title_q) begin
							phase_next = gcode_pkg::POST_TITLE;
						end else if (rd_data != CHAR_SPACE) begin
							state_next = gcode_pkg::FINISH;
							err_next = 1'b1;
						end
					end
					gcode_pkg::POST_TITLE: begin
						if (rd_data == CHAR_NL) begin
							state_next = gcode_pkg::FINISH;
						end else if (rd_data == CHAR_MINUS) begin
							neg_next = 1'b1;
							phase_next = gcode_pkg::SIGN_OR_DIGIT;
						end else if (is_digit) begin
							ev.int_digit = 1'b1;
							saw_next = 1'b1;
							phase_next = gcode_pkg::INT_DIGITS;
						end else if (rd_data == CHAR_DOT) begin
							phase_next = gcode_pkg::FRAC_DIGITS;
						end else if (rd_data != CHAR_SPACE) begin
							state_next = gcode_pkg::FINISH;
							err_next = 1'b1;
						end
					end
					gcode_pkg::SIGN_OR_DIGIT, gcode_pkg::INT_DIGITS: begin
						if (is_end) begin
							state_next = gcode_pkg::FINISH;
						end else if (is_digit) begin
							ev.int_digit = 1'b1;
							saw_next = 1'b1;
							phase_next = gcode_pkg::INT_DIGITS;
						end else if (rd_data == CHAR_DOT) begin
							phase_next = gcode_pkg::FRAC_DIGITS;
						end else begin
							state_next = gcode_pkg::FINISH; // a second minus lands here too.
							err_next = 1'b1;
						end
					end
					gcode_pkg::FRAC_DIGITS: begin
						if (is_end) begin
							state_next = gcode_pkg::FINISH;
						end else if (is_digit) begin
							ev.frac_digit = 1'b1;
							saw_next = 1'b1;
						end else begin
							state_next = gcode_pkg::FINISH;
							err_next = 1'b1;
						end
					end
					default: begin
						state_next = gcode_pkg::FINISH;
						err_next = 1'b1;
					end
				endcase
			end
			gcode_pkg::FINISH: begin
				state_next = gcode_pkg::IDLE;
			end
			default: begin
				state_next = gcode_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge sub_intf) begin
		if (start && rdy) begin
			title_q <= title;
		end
	end

	always_ff @(posedge sub_intf or negedge arst_n) begin
		if (!arst_n) begin
			state <= gcode_pkg::IDLE;
			phase <= gcode_pkg::LEAD_SPACE;
			negative_q <= 1'b0;
			saw_digit_q <= 1'b0;
			syntax_error_q <= 1'b0;
			finish_d <= 1'b0;
		end else begin
			state <= state_next;
			phase <= phase_next;
			negative_q <= neg_next;
			saw_digit_q <= saw_next;
			syntax_error_q <= err_next;
			finish_d <= state == gcode_pkg::FINISH; // lines up with done from the combiner.
		end
	end

endmodule

// ==== src/int_accum.sv ====
`timescale 1ns/1ps
`include "gcode_cfg.svh"

module int_accum (
	input logic sub_intf,
	input logic arst_n,
	input gcode_pkg::digit_ev_t ev,
	output gcode_pkg::accum_int_t acc
);

	logic [`POS_BITS+3:0] wide_mag;
	logic [`POS_BITS+3:0] wide_digit;
	logic [`POS_BITS+3:0] next_val;

	assign wide_mag = {4'b0000, acc.mag};
	assign wide_digit = {{`POS_BITS{1'b0}}, ev.value};
	assign next_val = (wide_mag << 3) + (wide_mag << 1) + wide_digit; // mag * 10 + digit.

	always_ff @(posedge sub_intf or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else if (ev.clear) begin
			acc <= '0;
		end else if (ev.int_digit && !acc.overflow) begin
			if (next_val > `POS_MAX) begin
				acc.overflow <= 1'b1; // magnitude stays frozen from here on.
			end else begin
				acc.mag <= next_val[`POS_BITS-1:0];
			end
		end
	end

endmodule

// ==== src/frac_accum.sv ====
`timescale 1ns/1ps

module frac_accum (
	input logic sub_intf,
	input logic arst_n,
	input gcode_pkg::digit_ev_t ev,
	output gcode_pkg::hund_t hundredths
);

	logic [1:0] digits_seen; // saturates at two.
	gcode_pkg::hund_t digit_wide;
	gcode_pkg::hund_t tenths;

	assign digit_wide = {3'b000, ev.value};
	assign tenths = (digit_wide << 3) + (digit_wide << 1);

	always_ff @(posedge sub_intf or negedge arst_n) begin
		if (!arst_n) begin
			digits_seen <= '0;
			hundredths <= '0;
		end else if (ev.clear) begin
			digits_seen <= '0;
			hundredths <= '0;
		end else if (ev.frac_digit) begin
			case (digits_seen)
				2'd0: begin
					hundredths <= tenths;
					digits_seen <= 2'd1;
				end
				2'd1: begin
					hundredths <= hundredths + digit_wide;
					digits_seen <= 2'd2;
				end
				default: begin
					digits_seen <= 2'd2; // further digits carry no weight.
				end
			endcase
		end
	end

endmodule

// ==== src/arg_combiner.sv ====
`timescale 1ns/1ps
`include "gcode_cfg.svh"

module arg_combiner (
	input logic sub_intf,
	input logic arst_n,
	input gcode_pkg::scan_status_t status,
	input gcode_pkg::accum_int_t acc,
	input gcode_pkg::hund_t hundredths,
	output gcode_pkg::pos_t num,
	output gcode_pkg::precise_t precise_num,
	output logic arg_too_big,
	output logic success,
	output logic done
);

	gcode_pkg::pos_t num_mag;
	logic [`PRECISE_BITS-1:0] mag_wide;
	logic [`PRECISE_BITS-1:0] hund_wide;
	logic [`PRECISE_BITS-1:0] precise_mag;
	logic ok;

	assign num_mag = gcode_pkg::pos_t'(acc.mag); // fits since the magnitude never passes the max.
	assign mag_wide = {{(`PRECISE_BITS-`POS_BITS){1'b0}}, acc.mag};
	assign hund_wide = {{(`PRECISE_BITS-7){1'b0}}, hundredths};
	assign precise_mag = (mag_wide * 7'd100) + hund_wide;
	assign ok = !status.syntax_error && !acc.overflow && status.saw_digit;

	always_ff @(posedge sub_intf or negedge arst_n) begin
		if (!arst_n) begin
			num <= '0;
			precise_num <= '0;
			arg_too_big <= 1'b0;
			success <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= status.finish;
			if (status.finish) begin
				arg_too_big <= acc.overflow;
				success <= ok;
				if (!ok) begin
					num <= '0;
					precise_num <= '0;
				end else if (status.negative) begin
					num <= -num_mag;
					precise_num <= -gcode_pkg::precise_t'(precise_mag);
				end else begin
					num <= num_mag;
					precise_num <= gcode_pkg::precise_t'(precise_mag);
				end
			end
		end
	end

endmodule

// ==== src/arg_subparser.sv ====
`timescale 1ns/1ps

module arg_subparser (
	input logic sub_intf,
	input logic arst_n,
	input logic wr_en,
	input gcode_pkg::char_t wr_data,
	output logic full,
	input logic start,
	input gcode_pkg::char_t title,
	output logic rdy,
	output logic done,
	output gcode_pkg::pos_t num,
	output gcode_pkg::precise_t precise_num,
	output logic arg_too_big,
	output logic success
);

	gcode_pkg::char_t rd_data;
	logic rd_en;
	logic empty;
	gcode_pkg::digit_ev_t ev;
	gcode_pkg::scan_status_t status;
	gcode_pkg::accum_int_t acc;
	gcode_pkg::hund_t hundredths;

	char_fifo i_char_fifo (
		.sub_intf(sub_intf),
		.arst_n(arst_n),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_data(rd_data),
		.empty(empty),
		.full(full)
	);

	arg_scanner i_arg_scanner (
		.sub_intf(sub_intf),
		.arst_n(arst_n),
		.start(start),
		.title(title),
		.rd_data(rd_data),
		.empty(empty),
		.rd_en(rd_en),
		.ev(ev),
		.status(status),
		.rdy(rdy)
	);

	int_accum i_int_accum (
		.sub_intf(sub_intf),
		.arst_n(arst_n),
		.ev(ev),
		.acc(acc)
	);

	frac_accum i_frac_accum (
		.sub_intf(sub_intf),
		.arst_n(arst_n),
		.ev(ev),
		.hundredths(hundredths)
	);

	arg_combiner i_arg_combiner (
		.sub_intf(sub_intf),
		.arst_n(arst_n),
		.status(status),
		.acc(acc),
		.hundredths(hundredths),
		.num(num),
		.precise_num(precise_num),
		.arg_too_big(arg_too_big),
		.success(success),
		.done(done)
	);

endmodule

// ==== tb/arg_subparser_tb.sv ====
`timescale 1ns/1ps
`include "gcode_cfg.svh"

module arg_subparser_tb;

	localparam int RANDOM_ARGS = 50;
	// about 60 arguments of 12 characters at two cycles each, four times over for gaps and stalls.
	localparam int CYCLE_LIMIT = 60 * 12 * 2 * 4 + 240;

	typedef struct packed {
		gcode_pkg::pos_t num;
		gcode_pkg::precise_t precise;
		logic too_big;
		logic success;
	} result_t;

	logic sub_intf = 1'b0;
	logic arst_n;
	logic wr_en;
	gcode_pkg::char_t wr_data;
	logic full;
	logic start;
	gcode_pkg::char_t title;
	logic rdy;
	logic done;
	gcode_pkg::pos_t num;
	gcode_pkg::precise_t precise_num;
	logic arg_too_big;
	logic success;

	gcode_pkg::char_t to_send[$]; // characters still waiting for the write port.
	gcode_pkg::char_t stream_mem [0:2047]; // every character the FIFO took, in order.
	int stream_len = 0;
	int queued_len = 0;
	int consumed_pos = 0;
	int starts = 0;
	int checks = 0;
	int gap = 0;
	int gap_max = 0;
	int cycles = 0;
	integer seed = 48;
	gcode_pkg::char_t cur_title = 8'h00;
	result_t expected;
	int used;
	logic ended;

	arg_subparser i_dut (.*);

	always #50 sub_intf = ~sub_intf;

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			stop_with_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, want));
		end
	endtask

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);
	endfunction

	// walks the accepted characters from first on, the way the scanner rules read them.
	function automatic result_t parse_ref(input int first, input gcode_pkg::char_t want,
			output int count, output logic finished);
		result_t res;
		gcode_pkg::char_t c;
		int i;
		int phase; // 0 before title, 1 after title, 2 integer part, 3 fraction part.
		int d;
		int mag;
		int hund;
		int nfrac;
		logic neg;
		logic saw;
		logic err;
		logic big;
		logic is_digit;
		logic is_end;
		phase = 0;
		mag = 0;
		hund = 0;
		nfrac = 0;
		neg = 1'b0;
		saw = 1'b0;
		err = 1'b0;
		big = 1'b0;
		finished = 1'b0;
		i = first;
		while (!finished && i < stream_len) begin
			c = stream_mem[i];
			i = i + 1;
			d = int'(c) - 48;
			is_digit = (c >= "0") && (c <= "9");
			is_end = (c == " ") || (c == "\n");
			if (phase == 0) begin
				if (c == want) begin
					phase = 1;
				end else if (c != " ") begin
					err = 1'b1;
				end
			end else if (phase == 1 && c == "\n") begin
				finished = 1'b1;
			end else if (phase == 1 && c == "-") begin
				neg = 1'b1;
				phase = 2;
			end else if (phase == 1 && c == " ") begin
				phase = 1;
			end else if (phase != 3 && is_digit) begin
				saw = 1'b1;
				phase = 2;
				if (!big && mag * 10 + d > `POS_MAX) begin
					big = 1'b1;
				end else if (!big) begin
					mag = mag * 10 + d;
				end
			end else if (phase != 3 && c == ".") begin
				phase = 3;
			end else if (phase == 3 && is_digit) begin
				saw = 1'b1;
				hund = (nfrac == 0) ? d * 10 : (nfrac == 1) ? hund + d : hund;
				nfrac = nfrac + 1;
			end else if (phase >= 2 && is_end) begin
				finished = 1'b1;
			end else begin
				err = 1'b1; // the offending character is used up.
			end
			finished = finished || err;
		end
		count = i - first;
		res.too_big = big;
		res.success = !err && !big && saw;
		res.num = '0;
		res.precise = '0;
		if (res.success) begin
			res.num = gcode_pkg::pos_t'(neg ? -mag : mag);
			res.precise = gcode_pkg::precise_t'(neg ? -(mag * 100 + hund) : mag * 100 + hund);
		end
		return res;
	endfunction

	always @(posedge sub_intf) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			stop_with_error($sformatf("timeout after %0d cycles without finishing", cycles));
		end
	end

	// the FIFO took the character if wr_en was high and full low at this edge.
	always @(posedge sub_intf) begin
		if (arst_n && rdy) begin
			// while the scanner idles, everything written but not yet parsed sits in the FIFO.
			check_value("full", 32'(full), 32'((stream_len - consumed_pos) == `FIFO_DEPTH));
		end
		if (wr_en && !full) begin
			stream_mem[stream_len] = wr_data;
			stream_len = stream_len + 1;
			void'(to_send.pop_front());
			if (gap_max > 0) begin
				gap = rand_below(gap_max + 1);
			end
		end
		if (gap > 0) begin
			gap = gap - 1;
			wr_en <= 1'b0;
		end else if (to_send.size() > 0) begin
			wr_en <= 1'b1;
			wr_data <= to_send[0];
		end else begin
			wr_en <= 1'b0;
		end
	end

	always @(negedge sub_intf) begin
		if (arst_n && done) begin
			expected = parse_ref(consumed_pos, cur_title, used, ended);
			if (checks >= starts) begin
				stop_with_error("done pulsed without an accepted start");
			end else if (!ended) begin
				stop_with_error("done arrived before the argument's terminator was written");
			end else begin
				check_value("num", 32'(num), 32'(expected.num));
				check_value("precise_num", 32'(precise_num), 32'(expected.precise));
				check_value("arg_too_big", 32'(arg_too_big), 32'(expected.too_big));
				check_value("success", 32'(success), 32'(expected.success));
				consumed_pos = consumed_pos + used;
				checks = checks + 1;
			end
		end
	end

	task automatic push_char(input gcode_pkg::char_t c);
		to_send.push_back(c);
		queued_len = queued_len + 1;
	endtask

	task automatic queue_string(input string s);
		int i;
		for (i = 0; i < s.len(); i++) begin
			push_char(s[i]);
		end
	endtask

	task automatic issue_start(input gcode_pkg::char_t t);
		@(posedge sub_intf);
		while (!rdy) begin
			@(posedge sub_intf);
		end
		start <= 1'b1;
		title <= t;
		cur_title = t;
		starts = starts + 1;
		@(posedge sub_intf);
		start <= 1'b0;
	endtask

	task automatic run_parse(input gcode_pkg::char_t t);
		issue_start(t);
		while (checks != starts) begin
			@(posedge sub_intf);
		end
	endtask

	// a failed parse leaves the rest of its argument behind, so parse until all of it is used.
	task automatic run_argument(input string s, input gcode_pkg::char_t t);
		queue_string(s);
		do begin
			run_parse(t);
		end while (consumed_pos < queued_len);
	endtask

	task automatic check_busy_start();
		queue_string("X 7.5 ");
		issue_start("X");
		repeat (2) @(posedge sub_intf);
		check_value("rdy", 32'(rdy), 32'd0);
		start <= 1'b1;
		@(posedge sub_intf);
		start <= 1'b0;
		while (checks != starts) begin
			@(posedge sub_intf);
		end
		repeat (6) @(posedge sub_intf);
		check_value("rdy", 32'(rdy), 32'd1); // a latched busy start would leave the scanner busy.
	endtask

	task automatic queue_random_arg();
		int k;
		int n_int;
		int n_frac;
		logic neg;
		logic dot;
		neg = rand_below(2) == 1;
		dot = rand_below(2) == 1;
		n_int = rand_below(6);
		n_frac = dot ? rand_below(4) : 0;
		for (k = rand_below(2); k > 0; k--) begin
			push_char(" ");
		end
		push_char("X");
		for (k = rand_below(2); k > 0; k--) begin
			push_char(" ");
		end
		if (neg) begin
			push_char("-");
		end
		for (k = 0; k < n_int; k++) begin
			push_char(8'h30 + 8'(rand_below(10)));
		end
		if (dot) begin
			push_char(".");
		end
		for (k = 0; k < n_frac; k++) begin
			push_char(8'h30 + 8'(rand_below(10)));
		end
		if (!neg && n_int == 0 && !dot) begin
			push_char("\n"); // a space right after the title would be skipped.
		end else begin
			push_char((rand_below(2) == 1) ? 8'h20 : 8'h0a);
		end
	endtask

	initial begin
		int n;
		arst_n = 1'b0;
		wr_en = 1'b0;
		wr_data = '0;
		start = 1'b0;
		title = '0;
		repeat (8) @(posedge sub_intf);
		arst_n <= 1'b1;
		@(posedge sub_intf);
		check_value("rdy", 32'(rdy), 32'd1);
		check_value("done", 32'(done), 32'd0);
		check_value("success", 32'(success), 32'd0);
		check_value("arg_too_big", 32'(arg_too_big), 32'd0);
		run_argument("X123.45 ", "X");
		run_argument("X -12.34 ", "X");
		run_argument("X.123 ", "X");
		run_argument("X123\n", "X");
		run_argument("Y 12.34\n", "X");
		run_argument("X 12.a3\n", "X");
		run_argument("X --5\n", "X");
		run_argument("X \n", "X");
		run_argument("X 8192.0 ", "X");
		run_argument("X 8191.99 ", "X");
		check_busy_start();
		gap_max = 5; // characters now trickle in while the parse waits.
		run_argument("X -45.67 ", "X");
		run_argument("  Z 9.5\n", "Z");
		gap_max = 0;
		for (n = 0; n < RANDOM_ARGS; n++) begin
			queue_random_arg();
		end
		while (consumed_pos < queued_len) begin
			run_parse("X");
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+src
src/gcode_pkg.sv
src/char_fifo.sv
src/arg_scanner.sv
src/int_accum.sv
src/frac_accum.sv
src/arg_combiner.sv
src/arg_subparser.sv
tb/arg_subparser_tb.sv

// ==== Makefile ====
TOOL       := verilator
TOP        := arg_subparser_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Finished with no errors" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
